/* axi_pkg.sv */
package axi_pkg;

   // AXI4 field widths
   localparam int axi_len_w   = 8;
   localparam int axi_id_w    = 1;
   localparam int axi_burst_w = 2;
   localparam int axi_lock_w  = 1;
   localparam int axi_cache_w = 4;
   localparam int axi_prot_w  = 3;
   localparam int axi_qos_w   = 4;
   localparam int axi_resp_w  = 2;

   // Burst type
   localparam logic [axi_burst_w-1:0] axi_burst_incr = 2'b01;

   // Normal non-cacheable modifiable
   localparam logic [axi_cache_w-1:0] axi_cache_mod = 4'b0010;

   // Unprivileged, non-secure, data access
   localparam logic [axi_prot_w-1:0] axi_prot_default = 3'b010;

   // Response codes
   localparam logic [axi_resp_w-1:0] axi_resp_okay   = 2'b00;
   localparam logic [axi_resp_w-1:0] axi_resp_slverr = 2'b10;

endpackage

/* iob2axi_rd.sv */
`timescale 1ns/100ps

module iob2axi_rd
   import axi_pkg::*;
#(
   parameter int addr_w = 16,
   parameter int data_w = 32
) (
   input  logic                   clk,
   input  logic                   rst,

   // Control side
   input  logic [axi_len_w-1:0]   length,
   output logic                   ready_ctl,
   output logic                   error,

   // Native read side
   output logic                   ready,
   input  logic                   valid,
   input  logic [addr_w-1:0]      addr,
   output logic [data_w-1:0]      rdata,

   // AXI4 read address channel
   output logic [axi_id_w-1:0]    m_axi_arid,
   output logic [addr_w-1:0]      m_axi_araddr,
   output logic [axi_len_w-1:0]   m_axi_arlen,
   output logic [2:0]             m_axi_arsize,
   output logic [axi_burst_w-1:0] m_axi_arburst,
   output logic [axi_lock_w-1:0]  m_axi_arlock,
   output logic [axi_cache_w-1:0] m_axi_arcache,
   output logic [axi_prot_w-1:0]  m_axi_arprot,
   output logic [axi_qos_w-1:0]   m_axi_arqos,
   output logic                   m_axi_arvalid,
   input  logic                   m_axi_arready,

   // AXI4 read data channel
   input  logic [axi_id_w-1:0]    m_axi_rid,
   input  logic [data_w-1:0]      m_axi_rdata,
   input  logic [axi_resp_w-1:0]  m_axi_rresp,
   input  logic                   m_axi_rlast,
   input  logic                   m_axi_rvalid,
   output logic                   m_axi_rready
);

   // Full-width beats only
   localparam logic [2:0] arsize = 3'($clog2(data_w / 8));

   typedef enum logic {
      st_addr_hs,
      st_read
   } state_t;

   state_t               state;
   logic [addr_w-1:0]    addr_reg;
   logic [axi_len_w-1:0] length_reg;
   logic [axi_len_w-1:0] counter;
   logic                 ar_start;
   logic                 arvalid_reg;
   logic                 start;
   logic                 beat;
   logic                 last_beat;

   assign start     = (state == st_addr_hs) && valid;
   assign beat      = (state == st_read) && valid && m_axi_rvalid;
   assign last_beat = beat && (counter == length_reg);

   assign ready_ctl = (state == st_addr_hs);

   // Native side follows the R channel directly
   assign ready        = (state == st_read) && m_axi_rvalid;
   assign m_axi_rready = (state == st_read) && valid;
   assign rdata        = m_axi_rdata;

   // Fixed request fields
   assign m_axi_arid    = '0;
   assign m_axi_araddr  = addr_reg;
   assign m_axi_arlen   = length_reg;
   assign m_axi_arsize  = arsize;
   assign m_axi_arburst = axi_burst_incr;
   assign m_axi_arlock  = '0;
   assign m_axi_arcache = axi_cache_mod;
   assign m_axi_arprot  = axi_prot_default;
   assign m_axi_arqos   = '0;
   assign m_axi_arvalid = arvalid_reg;

   // Request captured while idle
   always_ff @(posedge clk) begin
      if (start) begin
         addr_reg   <= addr;
         length_reg <= length;
      end
   end

   // Address valid goes out one cycle after the capture
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ar_start    <= 1'b0;
         arvalid_reg <= 1'b0;
      end else begin
         ar_start <= start;
         if (ar_start) begin
            arvalid_reg <= 1'b1;
         end else if (m_axi_arready) begin
            arvalid_reg <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= st_addr_hs;
         counter <= '0;
         error   <= 1'b0;
      end else begin
         case (state)
            st_addr_hs: begin
               counter <= '0;
               if (valid) begin
                  state <= st_read;
               end
            end
            st_read: begin
               if (beat) begin
                  counter <= counter + 1'b1;
               end
               // Slave must flag the final beat
               if (last_beat) begin
                  error <= ~m_axi_rlast;
                  state <= st_addr_hs;
               end
            end
            default: state <= st_addr_hs;
         endcase
      end
   end

endmodule

/* iob2axi_wr.sv */
`timescale 1ns/100ps

module iob2axi_wr
   import axi_pkg::*;
#(
   parameter int addr_w = 16,
   parameter int data_w = 32
) (
   input  logic                   clk,
   input  logic                   rst,

   // Control side
   input  logic [axi_len_w-1:0]   length,
   output logic                   ready_ctl,
   output logic                   error,

   // Native write side
   output logic                   ready,
   input  logic                   valid,
   input  logic [addr_w-1:0]      addr,
   input  logic [data_w-1:0]      wdata,
   input  logic [data_w/8-1:0]    wstrb,

   // AXI4 write address channel
   output logic [axi_id_w-1:0]    m_axi_awid,
   output logic [addr_w-1:0]      m_axi_awaddr,
   output logic [axi_len_w-1:0]   m_axi_awlen,
   output logic [2:0]             m_axi_awsize,
   output logic [axi_burst_w-1:0] m_axi_awburst,
   output logic [axi_lock_w-1:0]  m_axi_awlock,
   output logic [axi_cache_w-1:0] m_axi_awcache,
   output logic [axi_prot_w-1:0]  m_axi_awprot,
   output logic [axi_qos_w-1:0]   m_axi_awqos,
   output logic                   m_axi_awvalid,
   input  logic                   m_axi_awready,

   // AXI4 write data channel
   output logic [data_w-1:0]      m_axi_wdata,
   output logic [data_w/8-1:0]    m_axi_wstrb,
   output logic                   m_axi_wlast,
   output logic                   m_axi_wvalid,
   input  logic                   m_axi_wready,

   // AXI4 write response channel
   input  logic [axi_id_w-1:0]    m_axi_bid,
   input  logic [axi_resp_w-1:0]  m_axi_bresp,
   input  logic                   m_axi_bvalid,
   output logic                   m_axi_bready
);

   localparam logic [2:0] awsize = 3'($clog2(data_w / 8));

   typedef enum logic [1:0] {
      st_addr_hs,
      st_write,
      st_resp
   } state_t;

   state_t               state;
   logic [addr_w-1:0]    addr_reg;
   logic [axi_len_w-1:0] length_reg;
   logic [axi_len_w-1:0] counter;
   logic                 aw_start;
   logic                 awvalid_reg;
   logic                 start;
   logic                 beat;

   assign start = (state == st_addr_hs) && valid;
   assign beat  = (state == st_write) && valid && m_axi_wready;

   assign ready_ctl = (state == st_addr_hs);

   // Native beats pass straight onto the W channel
   assign ready        = (state == st_write) && m_axi_wready;
   assign m_axi_wvalid = (state == st_write) && valid;
   assign m_axi_wdata  = wdata;
   assign m_axi_wstrb  = wstrb;
   assign m_axi_wlast  = (state == st_write) && (counter == length_reg);
   assign m_axi_bready = (state == st_resp);

   assign m_axi_awid    = '0;
   assign m_axi_awaddr  = addr_reg;
   assign m_axi_awlen   = length_reg;
   assign m_axi_awsize  = awsize;
   assign m_axi_awburst = axi_burst_incr;
   assign m_axi_awlock  = '0;
   assign m_axi_awcache = axi_cache_mod;
   assign m_axi_awprot  = axi_prot_default;
   assign m_axi_awqos   = '0;
   assign m_axi_awvalid = awvalid_reg;

   always_ff @(posedge clk) begin
      if (start) begin
         addr_reg   <= addr;
         length_reg <= length;
      end
   end

   // Delayed address valid, held until accepted
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         aw_start    <= 1'b0;
         awvalid_reg <= 1'b0;
      end else begin
         aw_start <= start;
         if (aw_start) begin
            awvalid_reg <= 1'b1;
         end else if (m_axi_awready) begin
            awvalid_reg <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= st_addr_hs;
         counter <= '0;
         error   <= 1'b0;
      end else begin
         case (state)
            st_addr_hs: begin
               counter <= '0;
               if (valid) begin
                  state <= st_write;
               end
            end
            st_write: begin
               if (beat) begin
                  counter <= counter + 1'b1;
                  if (m_axi_wlast) begin
                     state <= st_resp;
                  end
               end
            end
            st_resp: begin
               // Any response other than OKAY is reported
               if (m_axi_bvalid) begin
                  error <= (m_axi_bresp != axi_resp_okay);
                  state <= st_addr_hs;
               end
            end
            default: state <= st_addr_hs;
         endcase
      end
   end

endmodule

/* axi_ram.sv */
`timescale 1ns/100ps

module axi_ram
   import axi_pkg::*;
#(
   parameter int addr_w     = 16,
   parameter int data_w     = 32,
   parameter int mem_addr_w = 10
) (
   input  logic                   clk,
   input  logic                   rst,

   // Read address channel
   input  logic [axi_id_w-1:0]    s_axi_arid,
   input  logic [addr_w-1:0]      s_axi_araddr,
   input  logic [axi_len_w-1:0]   s_axi_arlen,
   input  logic [2:0]             s_axi_arsize,
   input  logic [axi_burst_w-1:0] s_axi_arburst,
   input  logic [axi_lock_w-1:0]  s_axi_arlock,
   input  logic [axi_cache_w-1:0] s_axi_arcache,
   input  logic [axi_prot_w-1:0]  s_axi_arprot,
   input  logic [axi_qos_w-1:0]   s_axi_arqos,
   input  logic                   s_axi_arvalid,
   output logic                   s_axi_arready,

   // Read data channel
   output logic [axi_id_w-1:0]    s_axi_rid,
   output logic [data_w-1:0]      s_axi_rdata,
   output logic [axi_resp_w-1:0]  s_axi_rresp,
   output logic                   s_axi_rlast,
   output logic                   s_axi_rvalid,
   input  logic                   s_axi_rready,

   // Write address channel
   input  logic [axi_id_w-1:0]    s_axi_awid,
   input  logic [addr_w-1:0]      s_axi_awaddr,
   input  logic [axi_len_w-1:0]   s_axi_awlen,
   input  logic [2:0]             s_axi_awsize,
   input  logic [axi_burst_w-1:0] s_axi_awburst,
   input  logic [axi_lock_w-1:0]  s_axi_awlock,
   input  logic [axi_cache_w-1:0] s_axi_awcache,
   input  logic [axi_prot_w-1:0]  s_axi_awprot,
   input  logic [axi_qos_w-1:0]   s_axi_awqos,
   input  logic                   s_axi_awvalid,
   output logic                   s_axi_awready,

   // Write data channel
   input  logic [data_w-1:0]      s_axi_wdata,
   input  logic [data_w/8-1:0]    s_axi_wstrb,
   input  logic                   s_axi_wlast,
   input  logic                   s_axi_wvalid,
   output logic                   s_axi_wready,

   // Write response channel
   output logic [axi_id_w-1:0]    s_axi_bid,
   output logic [axi_resp_w-1:0]  s_axi_bresp,
   output logic                   s_axi_bvalid,
   input  logic                   s_axi_bready
);

   localparam int strb_w = data_w / 8;
   localparam int lsb    = $clog2(strb_w);

   logic [data_w-1:0]     mem [2**mem_addr_w];
   logic [mem_addr_w-1:0] rd_ptr;
   logic [mem_addr_w-1:0] wr_ptr;
   logic [axi_len_w-1:0]  rd_cnt;
   logic                  wr_active;
   logic                  ar_hs;
   logic                  r_hs;
   logic                  aw_hs;
   logic                  w_hs;

   assign ar_hs = s_axi_arvalid && s_axi_arready;
   assign r_hs  = s_axi_rvalid && s_axi_rready;
   assign aw_hs = s_axi_awvalid && s_axi_awready;
   assign w_hs  = s_axi_wvalid && s_axi_wready;

   // One burst at a time per direction
   assign s_axi_arready = !s_axi_rvalid;
   assign s_axi_rlast   = s_axi_rvalid && (rd_cnt == '0);
   assign s_axi_awready = !wr_active && !s_axi_bvalid;
   assign s_axi_wready  = wr_active;

   // Read engine
   // rd_cnt counts the beats still to go after the current one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s_axi_rvalid <= 1'b0;
         s_axi_rid    <= '0;
         s_axi_rresp  <= axi_resp_okay;
         rd_cnt       <= '0;
      end else if (ar_hs) begin
         s_axi_rvalid <= 1'b1;
         s_axi_rid    <= s_axi_arid;
         s_axi_rresp  <= (s_axi_arburst == axi_burst_incr) ? axi_resp_okay : axi_resp_slverr;
         rd_cnt       <= s_axi_arlen;
      end else if (r_hs) begin
         if (s_axi_rlast) begin
            s_axi_rvalid <= 1'b0;
         end else begin
            rd_cnt <= rd_cnt - 1'b1;
         end
      end
   end

   // Next word is fetched as the current one is taken
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         s_axi_rdata <= mem[s_axi_araddr[lsb +: mem_addr_w]];
         rd_ptr      <= s_axi_araddr[lsb +: mem_addr_w] + 1'b1;
      end else if (r_hs && !s_axi_rlast) begin
         s_axi_rdata <= mem[rd_ptr];
         rd_ptr      <= rd_ptr + 1'b1;
      end
   end

   // Write engine
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_active    <= 1'b0;
         s_axi_bvalid <= 1'b0;
         s_axi_bid    <= '0;
         s_axi_bresp  <= axi_resp_okay;
      end else if (aw_hs) begin
         wr_active   <= 1'b1;
         s_axi_bid   <= s_axi_awid;
         s_axi_bresp <= (s_axi_awburst == axi_burst_incr) ? axi_resp_okay : axi_resp_slverr;
      end else if (w_hs && s_axi_wlast) begin
         wr_active    <= 1'b0;
         s_axi_bvalid <= 1'b1;
      end else if (s_axi_bvalid && s_axi_bready) begin
         s_axi_bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         wr_ptr <= s_axi_awaddr[lsb +: mem_addr_w];
      end else if (w_hs) begin
         for (int i = 0; i < strb_w; i++) begin
            if (s_axi_wstrb[i]) begin
               mem[wr_ptr][8*i +: 8] <= s_axi_wdata[8*i +: 8];
            end
         end
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

endmodule

/* iob2axi_sys.sv */
`timescale 1ns/100ps

module iob2axi_sys
   import axi_pkg::*;
#(
   parameter int addr_w     = 16,
   parameter int data_w     = 32,
   parameter int mem_addr_w = 10
) (
   input  logic                 clk,
   input  logic                 rst,

   // Read bridge control and native side
   input  logic [axi_len_w-1:0] rd_length,
   output logic                 rd_ready_ctl,
   output logic                 rd_error,
   output logic                 rd_ready,
   input  logic                 rd_valid,
   input  logic [addr_w-1:0]    rd_addr,
   output logic [data_w-1:0]    rd_rdata,

   // Write bridge control and native side
   input  logic [axi_len_w-1:0] wr_length,
   output logic                 wr_ready_ctl,
   output logic                 wr_error,
   output logic                 wr_ready,
   input  logic                 wr_valid,
   input  logic [addr_w-1:0]    wr_addr,
   input  logic [data_w-1:0]    wr_wdata,
   input  logic [data_w/8-1:0]  wr_wstrb
);

   // AR and R channels
   logic [axi_id_w-1:0]    m_axi_arid, m_axi_rid;
   logic [addr_w-1:0]      m_axi_araddr;
   logic [axi_len_w-1:0]   m_axi_arlen;
   logic [2:0]             m_axi_arsize;
   logic [axi_burst_w-1:0] m_axi_arburst;
   logic [axi_lock_w-1:0]  m_axi_arlock;
   logic [axi_cache_w-1:0] m_axi_arcache;
   logic [axi_prot_w-1:0]  m_axi_arprot;
   logic [axi_qos_w-1:0]   m_axi_arqos;
   logic                   m_axi_arvalid, m_axi_arready;
   logic [data_w-1:0]      m_axi_rdata;
   logic [axi_resp_w-1:0]  m_axi_rresp;
   logic                   m_axi_rlast, m_axi_rvalid, m_axi_rready;

   // AW, W and B channels
   logic [axi_id_w-1:0]    m_axi_awid, m_axi_bid;
   logic [addr_w-1:0]      m_axi_awaddr;
   logic [axi_len_w-1:0]   m_axi_awlen;
   logic [2:0]             m_axi_awsize;
   logic [axi_burst_w-1:0] m_axi_awburst;
   logic [axi_lock_w-1:0]  m_axi_awlock;
   logic [axi_cache_w-1:0] m_axi_awcache;
   logic [axi_prot_w-1:0]  m_axi_awprot;
   logic [axi_qos_w-1:0]   m_axi_awqos;
   logic                   m_axi_awvalid, m_axi_awready;
   logic [data_w-1:0]      m_axi_wdata;
   logic [data_w/8-1:0]    m_axi_wstrb;
   logic                   m_axi_wlast, m_axi_wvalid, m_axi_wready;
   logic [axi_resp_w-1:0]  m_axi_bresp;
   logic                   m_axi_bvalid, m_axi_bready;

   // Bridge AXI ports match the wire names above
   iob2axi_rd #(
      .addr_w(addr_w),
      .data_w(data_w)
   ) u_rd (
      .length(rd_length), .ready_ctl(rd_ready_ctl), .error(rd_error),
      .ready(rd_ready), .valid(rd_valid), .addr(rd_addr), .rdata(rd_rdata),
      .*
   );

   iob2axi_wr #(
      .addr_w(addr_w),
      .data_w(data_w)
   ) u_wr (
      .length(wr_length), .ready_ctl(wr_ready_ctl), .error(wr_error),
      .ready(wr_ready), .valid(wr_valid), .addr(wr_addr),
      .wdata(wr_wdata), .wstrb(wr_wstrb),
      .*
   );

   axi_ram #(
      .addr_w(addr_w),
      .data_w(data_w),
      .mem_addr_w(mem_addr_w)
   ) u_ram (
      .clk(clk), .rst(rst),
      .s_axi_arid(m_axi_arid), .s_axi_araddr(m_axi_araddr), .s_axi_arlen(m_axi_arlen),
      .s_axi_arsize(m_axi_arsize), .s_axi_arburst(m_axi_arburst),
      .s_axi_arlock(m_axi_arlock), .s_axi_arcache(m_axi_arcache),
      .s_axi_arprot(m_axi_arprot), .s_axi_arqos(m_axi_arqos),
      .s_axi_arvalid(m_axi_arvalid), .s_axi_arready(m_axi_arready),
      .s_axi_rid(m_axi_rid), .s_axi_rdata(m_axi_rdata), .s_axi_rresp(m_axi_rresp),
      .s_axi_rlast(m_axi_rlast), .s_axi_rvalid(m_axi_rvalid), .s_axi_rready(m_axi_rready),
      .s_axi_awid(m_axi_awid), .s_axi_awaddr(m_axi_awaddr), .s_axi_awlen(m_axi_awlen),
      .s_axi_awsize(m_axi_awsize), .s_axi_awburst(m_axi_awburst),
      .s_axi_awlock(m_axi_awlock), .s_axi_awcache(m_axi_awcache),
      .s_axi_awprot(m_axi_awprot), .s_axi_awqos(m_axi_awqos),
      .s_axi_awvalid(m_axi_awvalid), .s_axi_awready(m_axi_awready),
      .s_axi_wdata(m_axi_wdata), .s_axi_wstrb(m_axi_wstrb), .s_axi_wlast(m_axi_wlast),
      .s_axi_wvalid(m_axi_wvalid), .s_axi_wready(m_axi_wready),
      .s_axi_bid(m_axi_bid), .s_axi_bresp(m_axi_bresp),
      .s_axi_bvalid(m_axi_bvalid), .s_axi_bready(m_axi_bready)
   );

endmodule

/* tb_iob2axi_sys.sv */
`timescale 1ns/100ps

module tb_iob2axi_sys
   import axi_pkg::*;
();

   localparam int addr_w     = 16;
   localparam int data_w     = 32;
   localparam int mem_addr_w = 10;
   localparam int strb_w     = data_w / 8;
   localparam int mem_words  = 2 ** mem_addr_w;
   localparam int max_wait   = 2000;

   logic                 clk;
   logic                 rst;
   logic [axi_len_w-1:0] rd_length;
   logic                 rd_ready_ctl;
   logic                 rd_error;
   logic                 rd_ready;
   logic                 rd_valid;
   logic [addr_w-1:0]    rd_addr;
   logic [data_w-1:0]    rd_rdata;
   logic [axi_len_w-1:0] wr_length;
   logic                 wr_ready_ctl;
   logic                 wr_error;
   logic                 wr_ready;
   logic                 wr_valid;
   logic [addr_w-1:0]    wr_addr;
   logic [data_w-1:0]    wr_wdata;
   logic [strb_w-1:0]    wr_wstrb;

   // Byte-wide reference copy of the RAM
   logic [7:0] model [mem_words*strb_w];

   iob2axi_sys u_iob2axi_sys (.*);

   always #20 clk = ~clk;

   task automatic check(input string name, input logic [63:0] actual,
                        input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
         $display("Test failures found");
         $fatal(1, "Simulation stopped on mismatch");
      end
   endtask

   task automatic abort_run(input string reason);
      $display("Run aborted at %0t: %s", $time, reason);
      $display("Test failures found");
      $fatal(1, "Simulation stopped");
   endtask

   // Little-endian word from the byte model
   function automatic logic [data_w-1:0] model_word(input int word);
      logic [data_w-1:0] w;
      for (int i = 0; i < strb_w; i++) begin
         w[8*i +: 8] = model[word*strb_w + i];
      end
      return w;
   endfunction

   task automatic write_burst(input int word, input int len, input bit rand_strb,
                              input bit stall);
      int                beats;
      int                waited;
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      waited = 0;
      while (!wr_ready_ctl) begin
         @(negedge clk);
         waited++;
         if (waited > max_wait) begin
            abort_run("write bridge never became idle");
         end
      end
      wr_addr   = addr_w'(word * strb_w);
      wr_length = axi_len_w'(len);
      data      = $urandom;
      strb      = rand_strb ? strb_w'($urandom) : '1;
      wr_wdata  = data;
      wr_wstrb  = strb;
      wr_valid  = 1'b1;
      @(negedge clk);
      check("wr_ready_ctl", wr_ready_ctl, 1'b0);
      beats  = 0;
      waited = 0;
      while (beats <= len) begin
         wr_valid = !(stall && ($urandom % 4 == 0));
         wr_wdata = data;
         wr_wstrb = strb;
         // Beat is taken at the coming rising edge
         if (wr_valid && wr_ready) begin
            for (int i = 0; i < strb_w; i++) begin
               if (strb[i]) begin
                  model[(word + beats)*strb_w + i] = data[8*i +: 8];
               end
            end
            beats++;
            data = $urandom;
            strb = rand_strb ? strb_w'($urandom) : '1;
         end
         @(negedge clk);
         waited++;
         if (waited > max_wait) begin
            abort_run("write data phase did not complete");
         end
      end
      wr_valid = 1'b0;
      waited   = 0;
      while (!wr_ready_ctl) begin
         @(negedge clk);
         waited++;
         if (waited > max_wait) begin
            abort_run("write response never arrived");
         end
      end
      check("wr_error", wr_error, 1'b0);
   endtask

   task automatic read_burst(input int word, input int len, input bit stall);
      int beats;
      int waited;
      waited = 0;
      while (!rd_ready_ctl) begin
         @(negedge clk);
         waited++;
         if (waited > max_wait) begin
            abort_run("read bridge never became idle");
         end
      end
      rd_addr   = addr_w'(word * strb_w);
      rd_length = axi_len_w'(len);
      rd_valid  = 1'b1;
      @(negedge clk);
      check("rd_ready_ctl", rd_ready_ctl, 1'b0);
      beats  = 0;
      waited = 0;
      while (!rd_ready_ctl) begin
         rd_valid = !(stall && ($urandom % 4 == 0));
         if (rd_valid && rd_ready) begin
            if (beats > len) begin
               abort_run("read bridge returned more beats than requested");
            end
            check("rd_rdata", rd_rdata, model_word(word + beats));
            beats++;
         end
         @(negedge clk);
         waited++;
         if (waited > max_wait) begin
            abort_run("read burst did not complete");
         end
      end
      rd_valid = 1'b0;
      check("rd beat count", beats, len + 1);
      check("rd_error", rd_error, 1'b0);
   endtask

   initial begin
      int unsigned seed_ret;
      int          len;
      int          len2;
      seed_ret  = $urandom(32'hce88af67);
      clk       = 1'b0;
      rst       = 1'b1;
      rd_length = '0;
      rd_valid  = 1'b0;
      rd_addr   = '0;
      wr_length = '0;
      wr_valid  = 1'b0;
      wr_addr   = '0;
      wr_wdata  = '0;
      wr_wstrb  = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check("rd_ready_ctl", rd_ready_ctl, 1'b1);
      check("wr_ready_ctl", wr_ready_ctl, 1'b1);
      check("rd_ready", rd_ready, 1'b0);
      check("wr_ready", wr_ready, 1'b0);
      check("rd_error", rd_error, 1'b0);
      check("wr_error", wr_error, 1'b0);

      // Whole memory written by back-to-back 256-beat bursts and then read back
      for (int b = 0; b < mem_words / 256; b++) begin
         write_burst(b * 256, 255, 1'b0, b[0]);
      end
      for (int b = 0; b < mem_words / 256; b++) begin
         read_burst(b * 256, 255, b[0]);
      end

      // Back-to-back single-beat bursts
      for (int i = 0; i < 8; i++) begin
         write_burst($urandom_range(mem_words - 1, 0), 0, 1'b0, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         read_burst($urandom_range(mem_words - 1, 0), 0, 1'b0);
      end

      // Random bursts with full strobes and idle gaps between them
      for (int i = 0; i < 40; i++) begin
         len = $urandom_range(15, 0);
         write_burst($urandom_range(mem_words - 1 - len, 0), len, 1'b0, 1'b0);
         repeat ($urandom_range(3, 0)) @(negedge clk);
         len = $urandom_range(15, 0);
         read_burst($urandom_range(mem_words - 1 - len, 0), len, 1'b0);
      end

      // Random strobes with stalls on both sides
      for (int i = 0; i < 40; i++) begin
         len = $urandom_range(15, 0);
         write_burst($urandom_range(mem_words - 1 - len, 0), len, 1'b1, 1'b1);
         len = $urandom_range(15, 0);
         read_burst($urandom_range(mem_words - 1 - len, 0), len, 1'b1);
      end

      // Reads and writes in flight together on separate halves
      for (int i = 0; i < 20; i++) begin
         len  = $urandom_range(15, 0);
         len2 = $urandom_range(15, 0);
         fork
            write_burst($urandom_range(mem_words/2 - 1 - len, 0), len, 1'b1, 1'b1);
            read_burst($urandom_range(mem_words - 1 - len2, mem_words/2), len2, 1'b1);
         join
      end

      // Sweep that reads back every word after all the updates
      for (int b = 0; b < mem_words / 256; b++) begin
         read_burst(b * 256, 255, 1'b1);
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

/* src.f */
axi_pkg.sv
iob2axi_rd.sv
iob2axi_wr.sv
axi_ram.sv
iob2axi_sys.sv
tb_iob2axi_sys.sv

/* Bender.yml */
package:
  name: iob2axi_sys

sources:
  - axi_pkg.sv
  - iob2axi_rd.sv
  - iob2axi_wr.sv
  - axi_ram.sv
  - iob2axi_sys.sv
  - target: test
    files:
      - tb_iob2axi_sys.sv
